// File: build.f
rtl/branch_pkg.sv
rtl/fu_data_if.sv
rtl/branch_decoder.sv
rtl/branch_compare.sv
rtl/branch_unit.sv
rtl/branch_resolve_top.sv
tb/branch_resolve_props.sv
tb/branch_resolve_tb.sv

// File: rtl/branch_compare.sv
// #########################################################################
// Branch condition stage
// #########################################################################

`timescale 1ns/1ps

module branch_compare (
    input  logic          clk_i,
    input  logic          rst_i,
    fu_data_if.consumer   dec_i,
    fu_data_if.producer   exe_o
);

    logic is_equal;
    logic less_signed;
    logic less_unsigned;
    logic cond;

    // the three basic relations, the six branches are these or their inverse
    assign is_equal      = (dec_i.operand_a == dec_i.operand_b);
    assign less_signed   = ($signed(dec_i.operand_a) < $signed(dec_i.operand_b));
    assign less_unsigned = (dec_i.operand_a < dec_i.operand_b);

    always_comb begin : condition
        // jumps fall through to taken
        cond = 1'b1;
        if (branch_pkg::op_is_branch(dec_i.operation)) begin
            case (dec_i.operation)
                branch_pkg::EQ:  cond = is_equal;
                branch_pkg::NE:  cond = !is_equal;
                branch_pkg::LTS: cond = less_signed;
                branch_pkg::GES: cond = !less_signed;
                branch_pkg::LTU: cond = less_unsigned;
                default:         cond = !less_unsigned;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exe_o.valid <= 1'b0;
        end else begin
            exe_o.valid <= dec_i.valid;
        end
    end

    // carry the rest of the bundle one stage on, together with the outcome
    always_ff @(posedge clk_i) begin
        exe_o.operation       <= dec_i.operation;
        exe_o.operand_a       <= dec_i.operand_a;
        exe_o.operand_b       <= dec_i.operand_b;
        exe_o.imm             <= dec_i.imm;
        exe_o.pc              <= dec_i.pc;
        exe_o.is_compressed   <= dec_i.is_compressed;
        exe_o.predict_cf      <= dec_i.predict_cf;
        exe_o.predict_address <= dec_i.predict_address;
        exe_o.cmp_res         <= cond;
    end

endmodule

// File: rtl/branch_decoder.sv
// #########################################################################
// Control-flow decode stage
// #########################################################################

`timescale 1ns/1ps

module branch_decoder (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          valid_i,
    input  branch_pkg::instr_u            instr_i,
    input  logic [branch_pkg::VLEN-1:0]   pc_i,
    input  logic [branch_pkg::VLEN-1:0]   rs1_i,
    input  logic [branch_pkg::VLEN-1:0]   rs2_i,
    input  logic                          is_compressed_i,
    input  branch_pkg::cf_e               predict_cf_i,
    input  logic [branch_pkg::VLEN-1:0]   predict_address_i,
    fu_data_if.producer                   dec_o
);

    branch_pkg::fu_op_e            op;
    logic [branch_pkg::VLEN-1:0]   imm;
    logic [branch_pkg::VLEN-1:0]   b_imm;
    logic [branch_pkg::VLEN-1:0]   i_imm;
    logic [branch_pkg::VLEN-1:0]   j_imm;
    logic [19:0]                   j_bits;

    // B-type offset is scattered over both ends of the word, bit 0 is implied zero
    assign b_imm = {{(branch_pkg::VLEN-12){instr_i.b.imm12}}, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};

    // plain 12-bit immediate for JALR
    assign i_imm = {{(branch_pkg::VLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    // the J-type fields occupy everything above rd
    assign j_bits = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3};

    // j_bits holds imm[20], imm[10:1], imm[11] and imm[19:12] from top to bottom
    assign j_imm = {{(branch_pkg::VLEN-20){j_bits[19]}}, j_bits[7:0], j_bits[8],
                    j_bits[18:9], 1'b0};

    always_comb begin : decode
        op  = branch_pkg::NONE;
        imm = i_imm;
        // opcode sits in the same bits in both views
        case (instr_i.b.opcode)
            branch_pkg::OPC_BRANCH: begin
                imm = b_imm;
                case (instr_i.b.funct3)
                    branch_pkg::F3_BEQ:  op = branch_pkg::EQ;
                    branch_pkg::F3_BNE:  op = branch_pkg::NE;
                    branch_pkg::F3_BLT:  op = branch_pkg::LTS;
                    branch_pkg::F3_BGE:  op = branch_pkg::GES;
                    branch_pkg::F3_BLTU: op = branch_pkg::LTU;
                    branch_pkg::F3_BGEU: op = branch_pkg::GEU;
                    // funct3 010 and 011 are reserved, leave them undecoded
                    default:             op = branch_pkg::NONE;
                endcase
            end
            branch_pkg::OPC_JAL: begin
                op  = branch_pkg::JAL;
                imm = j_imm;
            end
            branch_pkg::OPC_JALR: begin
                if (instr_i.i.funct3 == branch_pkg::F3_JALR) begin
                    op = branch_pkg::JALR;
                end
            end
            default: op = branch_pkg::NONE;
        endcase
    end

    // only recognised control flow travels on, everything else is dropped here
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= valid_i && (op != branch_pkg::NONE);
        end
    end

    // payload follows the strobe without reset
    always_ff @(posedge clk_i) begin
        dec_o.operation       <= op;
        dec_o.imm             <= imm;
        dec_o.operand_a       <= rs1_i;
        dec_o.operand_b       <= rs2_i;
        dec_o.pc              <= pc_i;
        dec_o.is_compressed   <= is_compressed_i;
        dec_o.predict_cf      <= predict_cf_i;
        dec_o.predict_address <= predict_address_i;
    end

endmodule

// File: rtl/branch_pkg.sv
// #########################################################################
// Branch resolution definitions
// #########################################################################

package branch_pkg;

    // address and operand width of the integer pipeline
    localparam int unsigned VLEN = 32;

    // major opcodes of the control-flow instructions
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // funct3 codes of the conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    // JALR only exists with a zero funct3
    localparam logic [2:0] F3_JALR = 3'b000;

    // operation handed down the pipe, NONE marks anything we do not resolve
    typedef enum logic [3:0] {
        NONE,
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        JAL,
        JALR
    } fu_op_e;

    // control-flow type as seen by the predictors
    typedef enum logic [2:0] {
        NoCF,
        Branch,
        Jump,
        JumpR,
        Return
    } cf_e;

    // one instruction word, read either with the B-type or the I-type layout
    // the J-type immediate is taken from the upper 20 bits of the I view
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    // true for the six conditional branches
    function automatic logic op_is_branch(fu_op_e op);
        return op inside {EQ, NE, LTS, GES, LTU, GEU};
    endfunction

endpackage

// File: rtl/branch_resolve_top.sv
// #########################################################################
// Branch resolution top level
// #########################################################################

`timescale 1ns/1ps

module branch_resolve_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          valid_i,
    input  logic [31:0]                   instr_i,
    input  logic [branch_pkg::VLEN-1:0]   pc_i,
    input  logic [branch_pkg::VLEN-1:0]   rs1_i,
    input  logic [branch_pkg::VLEN-1:0]   rs2_i,
    input  logic [branch_pkg::VLEN-1:0]   predict_address_i,
    input  logic                          is_compressed_i,
    input  branch_pkg::cf_e               predict_cf_i,
    output logic                          resolve_o,
    output logic                          taken_o,
    output logic                          mispredict_o,
    output logic [branch_pkg::VLEN-1:0]   pc_o,
    output logic [branch_pkg::VLEN-1:0]   target_o,
    output logic [branch_pkg::VLEN-1:0]   link_o,
    output branch_pkg::cf_e               cf_type_o
);

    // decode to execute and execute to resolution
    fu_data_if dec_q ();
    fu_data_if exe_q ();

    // the raw word is reinterpreted as the instruction union at the port
    branch_decoder u_branch_decoder (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .valid_i           (valid_i),
        .instr_i           (instr_i),
        .pc_i              (pc_i),
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .is_compressed_i   (is_compressed_i),
        .predict_cf_i      (predict_cf_i),
        .predict_address_i (predict_address_i),
        .dec_o             (dec_q)
    );

    branch_compare u_branch_compare (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dec_i (dec_q),
        .exe_o (exe_q)
    );

    // purely combinational, so the outputs follow exe_q in the same cycle
    branch_unit u_branch_unit (
        .exe_i        (exe_q),
        .resolve_o    (resolve_o),
        .taken_o      (taken_o),
        .mispredict_o (mispredict_o),
        .pc_o         (pc_o),
        .target_o     (target_o),
        .link_o       (link_o),
        .cf_type_o    (cf_type_o)
    );

endmodule

// File: rtl/branch_unit.sv
// #########################################################################
// Branch resolution stage
// #########################################################################

`timescale 1ns/1ps

module branch_unit (
    fu_data_if.consumer                   exe_i,
    output logic                          resolve_o,
    output logic                          taken_o,
    output logic                          mispredict_o,
    output logic [branch_pkg::VLEN-1:0]   pc_o,
    output logic [branch_pkg::VLEN-1:0]   target_o,
    output logic [branch_pkg::VLEN-1:0]   link_o,
    output branch_pkg::cf_e               cf_type_o
);

    logic                          is_jalr;
    logic [branch_pkg::VLEN-1:0]   jump_base;
    logic [branch_pkg::VLEN-1:0]   target;
    logic [branch_pkg::VLEN-1:0]   next_pc;
    logic [branch_pkg::VLEN-1:0]   pc_step;

    assign is_jalr = (exe_i.operation == branch_pkg::JALR);

    // JALR jumps relative to rs1, every other control flow relative to its own pc
    assign jump_base = is_jalr ? exe_i.operand_a : exe_i.pc;

    // a compressed instruction is only half a word long
    assign pc_step = exe_i.is_compressed ? branch_pkg::VLEN'(2) : branch_pkg::VLEN'(4);
    assign next_pc = exe_i.pc + pc_step;

    always_comb begin : target_calc
        target = jump_base + exe_i.imm;
        // the ISA drops the lowest bit of a register jump target
        if (is_jalr) begin
            target[0] = 1'b0;
        end
    end

    // the link value and the pc are reported even when nothing resolves
    assign link_o = next_pc;
    assign pc_o   = exe_i.pc;

    always_comb begin : resolve
        resolve_o    = exe_i.valid;
        taken_o      = 1'b0;
        mispredict_o = 1'b0;
        target_o     = '0;
        // keep the front end's guess unless we learn better below
        cf_type_o    = exe_i.predict_cf;

        if (exe_i.valid) begin
            taken_o = exe_i.cmp_res;
            // a not-taken branch continues at the next sequential instruction
            target_o = exe_i.cmp_res ? target : next_pc;

            if (branch_pkg::op_is_branch(exe_i.operation)) begin
                // the branch history only cares about branches
                cf_type_o = branch_pkg::Branch;
                // predicted taken is encoded as a predicted Branch type
                mispredict_o = exe_i.cmp_res != (exe_i.predict_cf == branch_pkg::Branch);
            end

            // a register jump is wrong when nothing was predicted or the address differs
            if (is_jalr && (exe_i.predict_cf == branch_pkg::NoCF ||
                            exe_i.predict_address != target)) begin
                mispredict_o = 1'b1;
                // returns are handled by the return stack, the BTB is left alone
                if (exe_i.predict_cf != branch_pkg::Return) begin
                    cf_type_o = branch_pkg::JumpR;
                end
            end

            // JAL has a fixed target known at fetch, so it is never reported wrong
        end
    end

endmodule

// File: rtl/fu_data_if.sv
// #########################################################################
// Decoded operation bundle
// #########################################################################

`timescale 1ns/1ps

interface fu_data_if;

    // qualifies everything else in the bundle
    logic                          valid;
    branch_pkg::fu_op_e            operation;
    logic [branch_pkg::VLEN-1:0]   operand_a;
    logic [branch_pkg::VLEN-1:0]   operand_b;
    // immediate, already sign-extended to full width
    logic [branch_pkg::VLEN-1:0]   imm;
    logic [branch_pkg::VLEN-1:0]   pc;
    logic                          is_compressed;
    // what the front end guessed for this instruction
    branch_pkg::cf_e               predict_cf;
    logic [branch_pkg::VLEN-1:0]   predict_address;
    // condition outcome, only meaningful after the execute stage
    logic                          cmp_res;

    modport producer (
        output valid, operation, operand_a, operand_b, imm, pc,
        output is_compressed, predict_cf, predict_address, cmp_res
    );

    modport consumer (
        input valid, operation, operand_a, operand_b, imm, pc,
        input is_compressed, predict_cf, predict_address, cmp_res
    );

endinterface

// File: run.sh
#!/bin/sh
# build and run the branch resolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module branch_resolve_tb -o sim_branch > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_branch > sim.log 2>&1
status=$?
cat sim.log

if [ $status -eq 0 ] && grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed with status $status"
exit 1

// File: tb/branch_resolve_props.sv
// #########################################################################
// Branch resolution assertions
// #########################################################################

`timescale 1ns/1ps

module branch_resolve_props (
    input logic clk_i,
    input logic rst_i,
    input logic valid_i,
    input logic resolve_o,
    input logic mispredict_o
);

    // a resolution needs a strobe two sampled edges back
    // the strobe is seen at edge N and the outputs are sampled high at edge N+2
    property resolve_has_strobe;
        @(posedge clk_i) disable iff (rst_i)
            resolve_o |-> $past(valid_i, 2);
    endproperty

    // a mispredict is only meaningful together with a resolution
    property mispredict_needs_resolve;
        @(posedge clk_i) disable iff (rst_i)
            mispredict_o |-> resolve_o;
    endproperty

    // the pipe is empty right after reset is released
    property quiet_after_reset;
        @(posedge clk_i)
            $fell(rst_i) |-> !resolve_o;
    endproperty

    a_resolve_has_strobe : assert property (resolve_has_strobe)
        else $error("resolve_o without a valid_i strobe two edges earlier");

    a_mispredict_needs_resolve : assert property (mispredict_needs_resolve)
        else $error("mispredict_o high while resolve_o is low");

    a_quiet_after_reset : assert property (quiet_after_reset)
        else $error("resolve_o high in the first cycle after reset");

endmodule

bind branch_resolve_top branch_resolve_props u_branch_resolve_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (valid_i),
    .resolve_o    (resolve_o),
    .mispredict_o (mispredict_o)
);

// File: tb/branch_resolve_tb.sv
// #########################################################################
// Branch resolution testbench
// #########################################################################

`timescale 1ns/1ps

module branch_resolve_tb;

    // one outstanding resolution, in issue order
    typedef struct packed {
        int unsigned                   index;
        int unsigned                   cycle;
        logic [branch_pkg::VLEN-1:0]   pc;
        logic                          taken;
        logic [branch_pkg::VLEN-1:0]   target;
        logic                          mispredict;
        branch_pkg::cf_e               cf_type;
        logic [branch_pkg::VLEN-1:0]   link;
    } expect_t;

    logic                          clk_i = 1'b0;
    logic                          rst_i;
    logic                          valid_i;
    logic [31:0]                   instr_i;
    logic [branch_pkg::VLEN-1:0]   pc_i;
    logic [branch_pkg::VLEN-1:0]   rs1_i;
    logic [branch_pkg::VLEN-1:0]   rs2_i;
    logic [branch_pkg::VLEN-1:0]   predict_address_i;
    logic                          is_compressed_i;
    branch_pkg::cf_e               predict_cf_i;
    logic                          resolve_o;
    logic                          taken_o;
    logic                          mispredict_o;
    logic [branch_pkg::VLEN-1:0]   pc_o;
    logic [branch_pkg::VLEN-1:0]   target_o;
    logic [branch_pkg::VLEN-1:0]   link_o;
    branch_pkg::cf_e               cf_type_o;

    expect_t       pending[$];
    int unsigned   cycle_count = 0;
    int unsigned   issued = 0;
    int unsigned   resolved = 0;
    int unsigned   vec_count = 0;
    logic [31:0]   rnd = 32'd4123;

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // counts rising edges, read only on the falling edge
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    branch_resolve_top u_branch_resolve_top (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .valid_i           (valid_i),
        .instr_i           (instr_i),
        .pc_i              (pc_i),
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .predict_address_i (predict_address_i),
        .is_compressed_i   (is_compressed_i),
        .predict_cf_i      (predict_cf_i),
        .resolve_o         (resolve_o),
        .taken_o           (taken_o),
        .mispredict_o      (mispredict_o),
        .pc_o              (pc_o),
        .target_o          (target_o),
        .link_o            (link_o),
        .cf_type_o         (cf_type_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [branch_pkg::VLEN-1:0] got,
                              input logic [branch_pkg::VLEN-1:0] exp, input int unsigned idx);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s in vector %0d: got %h, expected %h",
                               name, idx, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             input int unsigned idx);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s in vector %0d: got %h, expected %h",
                               name, idx, got, exp));
        end
    endtask

    task automatic check_cf(input string name, input branch_pkg::cf_e got,
                            input branch_pkg::cf_e exp, input int unsigned idx);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s in vector %0d: got %h, expected %h",
                               name, idx, got, exp));
        end
    endtask

    // outputs settle after the rising edge, so they are sampled on the falling one
    always @(negedge clk_i) begin : monitor
        expect_t head;
        if (rst_i !== 1'b1) begin
            if (resolve_o === 1'b1) begin
                if (pending.size() == 0) begin
                    fail_run("resolve_o was raised with no control-flow instruction pending");
                end else begin
                    head = pending.pop_front();
                    // every resolution is due exactly two edges after its strobe was taken
                    if (head.cycle != cycle_count) begin
                        fail_run($sformatf("vector %0d resolved in cycle %0d instead of %0d",
                                           head.index, cycle_count, head.cycle));
                    end
                    check_addr("pc_o", pc_o, head.pc, head.index);
                    check_bit("taken_o", taken_o, head.taken, head.index);
                    check_addr("target_o", target_o, head.target, head.index);
                    check_bit("mispredict_o", mispredict_o, head.mispredict, head.index);
                    check_cf("cf_type_o", cf_type_o, head.cf_type, head.index);
                    check_addr("link_o", link_o, head.link, head.index);
                    resolved = resolved + 1;
                end
            end else if (pending.size() != 0 && pending[0].cycle <= cycle_count) begin
                fail_run($sformatf("timeout: vector %0d was not resolved by cycle %0d",
                                   pending[0].index, cycle_count));
            end
        end
    end

    initial begin : stimulus
        int                            fd;
        int                            n;
        int unsigned                   gap;
        int unsigned                   waited;
        logic [8*256-1:0]              line;
        logic [31:0]                   v_instr;
        logic [branch_pkg::VLEN-1:0]   v_pc;
        logic [branch_pkg::VLEN-1:0]   v_rs1;
        logic [branch_pkg::VLEN-1:0]   v_rs2;
        logic [branch_pkg::VLEN-1:0]   v_paddr;
        logic [branch_pkg::VLEN-1:0]   v_target;
        logic [branch_pkg::VLEN-1:0]   v_link;
        logic                          v_c;
        logic                          v_taken;
        logic                          v_mp;
        logic [2:0]                    v_pcf;
        logic [2:0]                    v_cf;
        expect_t                       rec;

        rst_i             = 1'b1;
        valid_i           = 1'b0;
        instr_i           = '0;
        pc_i              = '0;
        rs1_i             = '0;
        rs2_i             = '0;
        predict_address_i = '0;
        is_compressed_i   = 1'b0;
        predict_cf_i      = branch_pkg::NoCF;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        fd = $fopen("tb/branch_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("could not open tb/branch_testdata.txt");
        end

        // comment and blank lines simply do not scan as twelve fields
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        v_instr, v_pc, v_rs1, v_rs2, v_c, v_pcf, v_paddr,
                        v_taken, v_target, v_mp, v_cf, v_link);
            if (n == 12) begin
                valid_i           = 1'b1;
                instr_i           = v_instr;
                pc_i              = v_pc;
                rs1_i             = v_rs1;
                rs2_i             = v_rs2;
                is_compressed_i   = v_c;
                predict_cf_i      = branch_pkg::cf_e'(v_pcf);
                predict_address_i = v_paddr;
                vec_count = vec_count + 1;
                // a cf_type of 7 marks an instruction that must be dropped
                if (v_cf != 3'h7) begin
                    rec.index      = vec_count;
                    rec.cycle      = cycle_count + 2;
                    rec.pc         = v_pc;
                    rec.taken      = v_taken;
                    rec.target     = v_target;
                    rec.mispredict = v_mp;
                    rec.cf_type    = branch_pkg::cf_e'(v_cf);
                    rec.link       = v_link;
                    pending.push_back(rec);
                    issued = issued + 1;
                end
                @(negedge clk_i);
                rnd = xorshift32(rnd);
                // now and then leave a hole with junk on the bus and no strobe
                if (rnd[2:0] == 3'd0) begin
                    gap = int'(rnd[4:3]) + 1;
                    valid_i = 1'b0;
                    instr_i = xorshift32(rnd);
                    pc_i    = rnd;
                    repeat (gap) @(negedge clk_i);
                end
            end
        end
        $fclose(fd);
        valid_i = 1'b0;

        waited = 0;
        while (pending.size() != 0) begin
            @(negedge clk_i);
            waited = waited + 1;
            if (waited > 16) begin
                fail_run("timeout while waiting for the last resolutions");
            end
        end

        // a few quiet cycles so a late stray resolve_o is still caught
        repeat (4) @(negedge clk_i);

        if (vec_count != 0 && resolved == issued) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("%0d vectors read, %0d resolutions seen for %0d expected",
                               vec_count, resolved, issued));
        end
    end

endmodule

// File: tb/branch_testdata.txt
// instr pc rs1 rs2 compressed predict_cf predict_address | taken target mispredict cf_type link
// cf codes 0 NoCF 1 Branch 2 Jump 3 JumpR 4 Return, a cf_type of 7 means no resolution expected
00208863 00001000 00000005 00000005 0 1 00001010 1 00001010 0 1 00001004
00208863 00001004 00000005 00000006 0 1 00001014 0 00001008 1 1 00001008
00209863 00001008 00000005 00000006 0 0 00000000 1 00001018 1 1 0000100c
fe209ce3 00001100 ffffffff ffffffff 0 0 00000000 0 00001104 0 1 00001104
0020c863 00002000 fffffffe 00000001 0 1 00002010 1 00002010 0 1 00002004
fe20cce3 00002004 00000001 fffffffe 0 1 00001ffc 0 00002008 1 1 00002008
0020d863 00002008 00000003 fffffffd 0 0 00000000 1 00002018 1 1 0000200c
0020d863 0000200c 80000000 80000000 0 1 0000201c 1 0000201c 0 1 00002010
0020d863 00002010 80000000 00000000 0 0 00000000 0 00002014 0 1 00002014
0020e863 00003000 00000001 fffffffe 0 1 00003010 1 00003010 0 1 00003004
0020e863 00003004 fffffffe 00000001 0 0 00000000 0 00003008 0 1 00003008
0020f863 00003008 fffffffe 00000001 0 0 00000000 1 00003018 1 1 0000300c
fe20fce3 00003100 00000000 00000001 0 1 000030f8 0 00003104 1 1 00003104
00208863 00003200 00000001 00000002 1 0 00000000 0 00003202 0 1 00003202
00100093 00004000 00000000 00000000 0 0 00000000 0 00000000 0 7 00000000
100000ef 00004004 00000000 00000000 0 2 00004104 1 00004104 0 2 00004008
ffdff0ef 00004100 00000000 00000000 1 0 00000000 1 000040fc 0 0 00004102
001000ef 00005000 00000000 00000000 0 2 00005800 1 00005800 0 2 00005004
000010ef 00005004 00000000 00000000 1 2 00006004 1 00006004 0 2 00005006
0000a083 00005008 00000010 00000000 0 0 00000000 0 00000000 0 7 00000000
008280e7 00006000 00008000 00000000 0 3 00008008 1 00008008 0 3 00006004
003280e7 00006004 00008000 00000000 0 3 00008000 1 00008002 1 3 00006008
ffc280e7 00006008 00009001 00000000 0 0 00000000 1 00008ffc 1 3 0000600c
00008067 00006100 00007004 00000000 1 4 00007004 1 00007004 0 4 00006102
00008067 00006104 00007008 00000000 0 4 00007004 1 00007008 1 4 00006108
000290e7 00006108 00001234 00000000 0 0 00000000 0 00000000 0 7 00000000
0020a863 0000610c 00000001 00000002 0 1 00000000 0 00000000 0 7 00000000
000280e7 00006200 0000a000 00000000 0 1 00006210 1 0000a000 1 3 00006204
000280e7 00006204 0000b000 00000000 0 2 0000b000 1 0000b000 0 2 00006208
